//--- data_feeder.f
+incdir+source
source/feeder_bus_pkg.sv
source/feeder_mem_pkg.sv
source/feeder_csr.sv
source/read_request_gen.sv
source/line_unpacker.sv
source/cmd_issuer.sv
source/data_feeder.sv
verification/data_feeder_chk.sv
verification/data_feeder_tb.sv

//--- source/cmd_issuer.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module cmd_issuer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  feeder_bus_pkg::cmd_kind_e       kind_i,
    input  logic [`FEEDER_IDX_W-1:0]        sram_idx_i,
    input  logic                            start_i,
    input  logic                            word_valid_i,
    input  logic [`FEEDER_WORD_W-1:0]       word_i,
    output logic                            word_ready_o,
    input  logic                            credit_i,
    output logic                            cmd_valid_o,
    output feeder_bus_pkg::acc_cmd_t        cmd_o,
    output logic                            busy_o
);
    localparam int CRW = $clog2(`FEEDER_CMD_CREDITS + 1);

    logic [CRW-1:0]             credits;
    logic [`FEEDER_IDX_W-1:0]   sram_idx;
    logic                       take;

    assign word_ready_o = (credits != '0);
    assign take         = word_valid_i && word_ready_o;
    assign busy_o       = cmd_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits     <= CRW'(`FEEDER_CMD_CREDITS);
            cmd_valid_o <= 1'b0;
        end else begin
            credits     <= credits + CRW'(credit_i) - CRW'(take);
            cmd_valid_o <= take;
        end
    end

    // index keeps counting across lines and rounds
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            sram_idx <= sram_idx_i;
        end else if (take) begin
            sram_idx <= sram_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            cmd_o <= '{kind: kind_i, word: word_i, idx: sram_idx};
        end
    end

endmodule

//--- source/data_feeder.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module data_feeder (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // cpu register port
    input  feeder_bus_pkg::mmio_req_t           mmio_i,
    output logic                                ready_o,
    output logic [31:0]                         rdata_o,
    // dram request side
    input  logic                                addr_full_i,
    input  logic                                rw_full_i,
    output logic                                req_valid_o,
    output feeder_mem_pkg::dram_req_t           req_o,
    // dram read data
    input  logic                                data_empty_i,
    input  logic [`FEEDER_LINE_BYTES*4-1:0]     data_h_i,
    input  logic [`FEEDER_LINE_BYTES*4-1:0]     data_l_i,
    output logic                                fifo_rd_en_o,
    // accelerator command port
    input  logic                                credit_i,
    output logic                                cmd_valid_o,
    output feeder_bus_pkg::acc_cmd_t            cmd_o
);
    import feeder_bus_pkg::*;
    import feeder_mem_pkg::*;

    job_cfg_t                   job;
    logic [`FEEDER_IDX_W-1:0]   sram_idx;
    logic                       start;
    logic                       req_busy;
    logic                       unp_busy;
    logic                       iss_busy;
    mem_line_u                  line_w;
    logic                       word_valid;
    logic                       word_ready;
    logic [`FEEDER_WORD_W-1:0]  word;
    logic [`FEEDER_WORD_W-1:0]  probe_word;

    always_comb begin
        line_w.half.hi = data_h_i;
        line_w.half.lo = data_l_i;
    end

    // ########################################################
    // stages
    // ########################################################
    feeder_csr feeder_csr_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mmio_i       (mmio_i),
        .ready_o      (ready_o),
        .rdata_o      (rdata_o),
        .job_o        (job),
        .sram_idx_o   (sram_idx),
        .start_o      (start),
        .busy_i       ({iss_busy, unp_busy, req_busy}),
        .probe_word_i (probe_word)
    );

    read_request_gen read_request_gen_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .job_i       (job),
        .start_i     (start),
        .addr_full_i (addr_full_i),
        .rw_full_i   (rw_full_i),
        .req_valid_o (req_valid_o),
        .req_o       (req_o),
        .busy_o      (req_busy)
    );

    line_unpacker line_unpacker_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .job_i        (job),
        .start_i      (start),
        .data_empty_i (data_empty_i),
        .line_i       (line_w),
        .fifo_rd_en_o (fifo_rd_en_o),
        .word_valid_o (word_valid),
        .word_o       (word),
        .word_ready_i (word_ready),
        .probe_word_o (probe_word),
        .busy_o       (unp_busy)
    );

    cmd_issuer cmd_issuer_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .kind_i       (job.kind),
        .sram_idx_i   (sram_idx),
        .start_i      (start),
        .word_valid_i (word_valid),
        .word_i       (word),
        .word_ready_o (word_ready),
        .credit_i     (credit_i),
        .cmd_valid_o  (cmd_valid_o),
        .cmd_o        (cmd_o),
        .busy_o       (iss_busy)
    );

endmodule

//--- source/data_feeder_cfg.svh
`ifndef DATA_FEEDER_CFG_SVH
`define DATA_FEEDER_CFG_SVH

// datapath widths
`define FEEDER_ADDR_W       32
`define FEEDER_WORD_W       16
`define FEEDER_LINE_BYTES   64
`define FEEDER_LINE_WORDS   32
`define FEEDER_IDX_W        15

// initial accelerator credits
`define FEEDER_CMD_CREDITS  4

// register map as byte offsets from the device base
`define FEEDER_REG_BASE       32'hC400_2000
`define FEEDER_REG_BUSY       (`FEEDER_REG_BASE + 32'h20)
`define FEEDER_REG_DRAM_ADDR  (`FEEDER_REG_BASE + 32'h24)
`define FEEDER_REG_LENGTH     (`FEEDER_REG_BASE + 32'h28)
`define FEEDER_REG_MODE       (`FEEDER_REG_BASE + 32'h2C)
`define FEEDER_REG_START      (`FEEDER_REG_BASE + 32'h30)
`define FEEDER_REG_SRAM_IDX   (`FEEDER_REG_BASE + 32'h34)
`define FEEDER_REG_KIND       (`FEEDER_REG_BASE + 32'h38)
`define FEEDER_REG_PROBE      (`FEEDER_REG_BASE + 32'h5C)
`define FEEDER_REG_RD_STRIDE  (`FEEDER_REG_BASE + 32'h70)
`define FEEDER_REG_RD_ROUNDS  (`FEEDER_REG_BASE + 32'h74)

`endif

//--- source/feeder_bus_pkg.sv
`include "data_feeder_cfg.svh"

package feeder_bus_pkg;

    // cpu register port
    typedef struct packed {
        logic                       strobe;
        logic [`FEEDER_ADDR_W-1:0]  addr;
        logic [31:0]                wdata;
    } mmio_req_t;

    typedef enum logic {
        CMD_LOAD_INPUT  = 1'b0,
        CMD_LOAD_WEIGHT = 1'b1
    } cmd_kind_e;

    // one load command to the accelerator
    typedef struct packed {
        cmd_kind_e                  kind;
        logic [`FEEDER_WORD_W-1:0]  word;
        logic [`FEEDER_IDX_W-1:0]   idx;    // scratchpad index
    } acc_cmd_t;

    typedef struct packed {
        logic [`FEEDER_ADDR_W-1:0]  start_addr;
        logic [`FEEDER_IDX_W-1:0]   length;     // in words
        logic [`FEEDER_ADDR_W-1:0]  stride;     // per round
        logic [`FEEDER_IDX_W-1:0]   rounds;
        cmd_kind_e                  kind;
        logic                       probe;
    } job_cfg_t;

endpackage

//--- source/feeder_csr.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module feeder_csr (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  feeder_bus_pkg::mmio_req_t   mmio_i,
    output logic                        ready_o,
    output logic [31:0]                 rdata_o,
    output feeder_bus_pkg::job_cfg_t    job_o,
    output logic [`FEEDER_IDX_W-1:0]    sram_idx_o,
    output logic                        start_o,
    input  logic [2:0]                  busy_i,
    input  logic [`FEEDER_WORD_W-1:0]   probe_word_i
);
    import feeder_bus_pkg::*;

    logic job_busy;
    logic start_hit;

    assign job_busy  = |busy_i;
    assign start_hit = mmio_i.strobe && (mmio_i.addr == `FEEDER_REG_START);

    // ########################################################
    // config registers
    // ########################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            job_o      <= '0;
            job_o.rounds <= {{(`FEEDER_IDX_W-1){1'b0}}, 1'b1};
            sram_idx_o <= '0;
        end else if (mmio_i.strobe) begin
            case (mmio_i.addr)
                `FEEDER_REG_DRAM_ADDR: job_o.start_addr <= mmio_i.wdata;
                `FEEDER_REG_LENGTH:    job_o.length     <= mmio_i.wdata[`FEEDER_IDX_W-1:0];
                `FEEDER_REG_RD_STRIDE: job_o.stride     <= mmio_i.wdata;
                `FEEDER_REG_RD_ROUNDS: job_o.rounds     <= mmio_i.wdata[`FEEDER_IDX_W-1:0];
                `FEEDER_REG_KIND:      job_o.kind       <= cmd_kind_e'(mmio_i.wdata[0]);
                `FEEDER_REG_MODE:      job_o.probe      <= mmio_i.wdata[0];
                `FEEDER_REG_SRAM_IDX:  sram_idx_o       <= mmio_i.wdata[`FEEDER_IDX_W-1:0];
                default: ;
            endcase
        end
    end

    // launch only from idle and once per start write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_o <= 1'b0;
        end else begin
            start_o <= start_hit && !job_busy && !start_o;
        end
    end

    // ########################################################
    // bus response
    // ########################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= mmio_i.strobe;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (mmio_i.strobe && mmio_i.addr == `FEEDER_REG_BUSY) begin
            rdata_o <= {31'b0, job_busy};
        end else if (mmio_i.strobe && mmio_i.addr == `FEEDER_REG_PROBE) begin
            rdata_o <= {{(32-`FEEDER_WORD_W){1'b0}}, probe_word_i};
        end
    end

endmodule

//--- source/feeder_mem_pkg.sv
`include "data_feeder_cfg.svh"

package feeder_mem_pkg;

    typedef struct packed {
        logic [`FEEDER_ADDR_W-1:0] addr;    // read start byte address
    } dram_req_t;

    typedef logic [$clog2(`FEEDER_LINE_WORDS)-1:0] word_idx_t;

    // halves as the data fifo delivers them
    typedef struct packed {
        logic [`FEEDER_LINE_BYTES*4-1:0] hi;
        logic [`FEEDER_LINE_BYTES*4-1:0] lo;
    } line_halves_t;

    // word k sits at bits 16k+15:16k, so words 0-15 are in the low half
    typedef union packed {
        line_halves_t                                       half;
        logic [`FEEDER_LINE_WORDS-1:0][`FEEDER_WORD_W-1:0]  word;
    } mem_line_u;

endpackage

//--- source/line_unpacker.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module line_unpacker (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  feeder_bus_pkg::job_cfg_t    job_i,
    input  logic                        start_i,
    input  logic                        data_empty_i,
    input  feeder_mem_pkg::mem_line_u   line_i,
    output logic                        fifo_rd_en_o,
    output logic                        word_valid_o,
    output logic [`FEEDER_WORD_W-1:0]   word_o,
    input  logic                        word_ready_i,
    output logic [`FEEDER_WORD_W-1:0]   probe_word_o,
    output logic                        busy_o
);
    import feeder_mem_pkg::*;

    typedef enum logic [2:0] {IDLE_S, WAIT_S, SEND_S, PROBE_S, POP_S} state_t;

    state_t                     state;
    mem_line_u                  line_r;
    word_idx_t                  idx;
    logic [`FEEDER_IDX_W-1:0]   sent;           // words sent this round
    logic [`FEEDER_IDX_W-1:0]   round_cnt;
    logic [`FEEDER_ADDR_W-1:0]  round_base;
    logic [`FEEDER_ADDR_W-1:0]  next_base;
    logic                       accept;

    assign next_base    = round_base + job_i.stride;
    assign word_valid_o = (state == SEND_S);
    assign word_o       = line_r.word[idx];
    assign accept       = word_valid_o && word_ready_i;
    assign fifo_rd_en_o = (state == POP_S);
    assign busy_o       = (state != IDLE_S);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE_S;
        end else begin
            case (state)
                IDLE_S: begin
                    if (start_i) begin
                        idx        <= job_i.start_addr[5:1];
                        sent       <= '0;
                        round_cnt  <= '0;
                        round_base <= job_i.start_addr;
                        state      <= WAIT_S;
                    end
                end
                WAIT_S: begin
                    if (!data_empty_i) begin
                        line_r <= line_i;
                        state  <= job_i.probe ? PROBE_S : SEND_S;
                    end
                end
                SEND_S: begin
                    if (accept) begin
                        idx  <= idx + 1'b1;         // wraps into the next line
                        sent <= sent + 1'b1;
                        if (idx == '1 || sent + 1'b1 == job_i.length) begin
                            state <= POP_S;
                        end
                    end
                end
                PROBE_S: begin
                    probe_word_o <= line_r.word[idx];
                    state        <= POP_S;
                end
                POP_S: begin
                    if (job_i.probe) begin
                        state <= IDLE_S;
                    end else if (sent != job_i.length) begin
                        state <= WAIT_S;
                    end else if (round_cnt + 1'b1 >= job_i.rounds) begin
                        state <= IDLE_S;
                    end else begin
                        // next round restarts at base plus stride
                        round_base <= next_base;
                        idx        <= next_base[5:1];
                        sent       <= '0;
                        round_cnt  <= round_cnt + 1'b1;
                        state      <= WAIT_S;
                    end
                end
                default: state <= IDLE_S;
            endcase
        end
    end

endmodule

//--- source/read_request_gen.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module read_request_gen (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  feeder_bus_pkg::job_cfg_t    job_i,
    input  logic                        start_i,
    input  logic                        addr_full_i,
    input  logic                        rw_full_i,
    output logic                        req_valid_o,
    output feeder_mem_pkg::dram_req_t   req_o,
    output logic                        busy_o
);
    localparam int CW = `FEEDER_IDX_W + 1;

    typedef enum logic [1:0] {IDLE_S, WAIT_S, SEND_S, NEXT_S} state_t;

    state_t                     state;
    logic [`FEEDER_ADDR_W-1:0]  addr;
    logic [`FEEDER_ADDR_W-1:0]  round_base;
    logic [CW-1:0]              covered;        // words requested this round
    logic [CW-1:0]              covered_next;
    logic [`FEEDER_IDX_W-1:0]   round_cnt;
    logic [6:0]                 step;           // bytes to the next line boundary

    assign step         = 7'd64 - {1'b0, addr[5:0]};
    assign covered_next = covered + CW'(step[6:1]);

    assign req_valid_o = (state == SEND_S);
    assign req_o.addr  = addr;
    assign busy_o      = (state != IDLE_S);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE_S;
        end else begin
            case (state)
                IDLE_S: begin
                    if (start_i) begin
                        addr       <= job_i.start_addr;
                        round_base <= job_i.start_addr;
                        covered    <= '0;
                        round_cnt  <= '0;
                        state      <= WAIT_S;
                    end
                end
                WAIT_S: begin
                    if (!addr_full_i && !rw_full_i) begin
                        state <= SEND_S;
                    end
                end
                SEND_S: begin
                    addr    <= addr + `FEEDER_ADDR_W'(step);
                    covered <= covered_next;
                    state   <= (covered_next >= CW'(job_i.length)) ? NEXT_S : WAIT_S;
                end
                NEXT_S: begin
                    if (round_cnt + 1'b1 >= job_i.rounds) begin
                        state <= IDLE_S;
                    end else begin
                        addr       <= round_base + job_i.stride;
                        round_base <= round_base + job_i.stride;
                        covered    <= '0;
                        round_cnt  <= round_cnt + 1'b1;
                        state      <= WAIT_S;
                    end
                end
                default: state <= IDLE_S;
            endcase
        end
    end

endmodule

//--- verification/data_feeder_chk.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module data_feeder_chk (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  feeder_bus_pkg::mmio_req_t   mmio_i,
    input  logic                        ready_i,
    input  logic                        data_empty_i,
    input  logic                        fifo_rd_en_i,
    input  logic                        cmd_valid_i,
    input  logic                        credit_i
);
    int outstanding;    // issued but not yet credited
    int assert_fails = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(cmd_valid_i) - int'(credit_i);
        end
    end

    credit_limit_a: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding <= `FEEDER_CMD_CREDITS)
        else begin
            assert_fails++;
            $error("more accelerator commands outstanding than credits");
        end

    pop_not_empty_a: assert property (@(posedge clk_i) disable iff (rst_i)
        fifo_rd_en_i |-> !data_empty_i)
        else begin
            assert_fails++;
            $error("data fifo popped while empty");
        end

    ready_after_strobe_a: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |-> $past(mmio_i.strobe))
        else begin
            assert_fails++;
            $error("ready without a strobe in the cycle before");
        end

endmodule

bind data_feeder data_feeder_chk data_feeder_chk_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mmio_i       (mmio_i),
    .ready_i      (ready_o),
    .data_empty_i (data_empty_i),
    .fifo_rd_en_i (fifo_rd_en_o),
    .cmd_valid_i  (cmd_valid_o),
    .credit_i     (credit_i)
);

//--- verification/data_feeder_tb.sv
`timescale 1ns/10ps
`include "data_feeder_cfg.svh"

module data_feeder_tb;
    import feeder_bus_pkg::*;
    import feeder_mem_pkg::*;

    localparam int SEED            = 54838;
    localparam int TOTAL_WORDS     = 32 + 40 + 96 + 16 + 8;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 24 + 2000;

    logic                               clk_i = 1'b0;
    logic                               rst_i;
    mmio_req_t                          mmio_i;
    logic                               ready_o;
    logic [31:0]                        rdata_o;
    logic                               addr_full_i;
    logic                               rw_full_i;
    logic                               req_valid_o;
    dram_req_t                          req_o;
    logic                               data_empty_i;
    logic [`FEEDER_LINE_BYTES*4-1:0]    data_h_i;
    logic [`FEEDER_LINE_BYTES*4-1:0]    data_l_i;
    logic                               fifo_rd_en_o;
    logic                               credit_i;
    logic                               cmd_valid_o;
    acc_cmd_t                           cmd_o;

    logic [31:0]    req_q[$];       // lines still to be returned
    dram_req_t      req_log[$];
    dram_req_t      exp_req[$];
    acc_cmd_t       cmd_log[$];
    acc_cmd_t       exp_cmd[$];
    int             gap;
    int             credit_owed;
    int             credit_wait;
    bit             line_present;
    bit             pop_pending;
    bit             hold_credits;
    string          cur_test;
    int             errors;
    int             test_errors;
    int             tests_run;
    int             tests_failed;

    data_feeder data_feeder_inst (.*);

    always #4 clk_i = ~clk_i;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired with test %s still running", cur_test);
        $display("Simulation failed");
        $finish;
    end

    // ############################################################
    // DRAM and accelerator models
    // ############################################################
    function automatic logic [15:0] word_val(input logic [31:0] line_addr, input logic [4:0] k);
        return {line_addr[13:6], 3'b101, k};
    endfunction

    task automatic present_line(input logic [31:0] addr);
        logic [511:0] l;
        for (int k = 0; k < `FEEDER_LINE_WORDS; k++) begin
            l[16*k +: 16] = word_val({addr[31:6], 6'b0}, 5'(k));
        end
        data_l_i     = l[255:0];
        data_h_i     = l[511:256];
        data_empty_i = 1'b0;
        line_present = 1'b1;
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (req_valid_o) begin
                req_q.push_back(req_o.addr);
                req_log.push_back(req_o);
            end
            if (cmd_valid_o) begin
                cmd_log.push_back(cmd_o);
                credit_owed++;
            end
            if (pop_pending) begin  // popped at the last rising edge
                line_present = 1'b0;
                data_empty_i = 1'b1;
                gap          = $urandom_range(3);
            end
            pop_pending = fifo_rd_en_o;
            if (!line_present && req_q.size() > 0) begin
                if (gap > 0) gap--;
                else present_line(req_q.pop_front());
            end
            credit_i = 1'b0;
            if (!hold_credits && credit_owed > 0) begin
                if (credit_wait > 0) begin
                    credit_wait--;
                end else begin
                    credit_i    = 1'b1;
                    credit_owed--;
                    credit_wait = $urandom_range(5);
                end
            end
            addr_full_i = ($urandom_range(3) == 0);
            rw_full_i   = ($urandom_range(7) == 0);
        end
    end

    // ############################################################
    // reporting and compares
    // ############################################################
    task automatic note_error(input string what);
        $display("%s: %s", cur_test, what);
        errors++;
        test_errors++;
    endtask

    task automatic check_req(input dram_req_t exp, input dram_req_t act);
        if (exp !== act) begin
            $display("error %s: request expected %h got %h", cur_test, exp.addr, act.addr);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_cmd(input acc_cmd_t exp, input acc_cmd_t act);
        if (exp !== act) begin
            $display("error %s: cmd expected kind %0d word %h idx %h got kind %0d word %h idx %h",
                     cur_test, exp.kind, exp.word, exp.idx, act.kind, act.word, act.idx);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_rdata(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: read data expected %h got %h", cur_test, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // ############################################################
    // bus and job helpers
    // ############################################################
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(negedge clk_i);
        mmio_i = '{strobe: 1'b1, addr: addr, wdata: wdata};
        @(negedge clk_i);
        if (ready_o !== 1'b1) note_error($sformatf("no ready one cycle after strobe to %h", addr));
        rdata         = rdata_o;
        mmio_i.strobe = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(addr, wdata, unused);
    endtask

    task automatic build_expected(input logic [31:0] start, input int len, input int stride,
                                  input int rounds, input cmd_kind_e kind, input int sram,
                                  input bit probe);
        logic [31:0] base;
        logic [31:0] addr;
        int          covered;
        int          n;
        acc_cmd_t    c;
        n = 0;
        for (int r = 0; r < rounds; r++) begin
            base    = start + r * stride;
            addr    = base;
            covered = 0;
            while (covered < len) begin  // each request runs to the next line boundary
                exp_req.push_back('{addr: addr});
                covered += (64 - addr[5:0]) / 2;
                addr    += 64 - addr[5:0];
            end
            for (int i = 0; i < len && !probe; i++) begin
                addr   = base + 2 * i;
                c.kind = kind;
                c.word = word_val({addr[31:6], 6'b0}, addr[5:1]);
                c.idx  = 15'(sram + n);
                exp_cmd.push_back(c);
                n++;
            end
        end
    endtask

    task automatic start_job(input logic [31:0] start, input int len, input int stride,
                             input int rounds, input cmd_kind_e kind, input int sram,
                             input bit probe);
        req_log.delete();
        cmd_log.delete();
        exp_req.delete();
        exp_cmd.delete();
        build_expected(start, len, stride, rounds, kind, sram, probe);
        reg_write(`FEEDER_REG_DRAM_ADDR, start);
        reg_write(`FEEDER_REG_LENGTH, len);
        reg_write(`FEEDER_REG_RD_STRIDE, stride);
        reg_write(`FEEDER_REG_RD_ROUNDS, rounds);
        reg_write(`FEEDER_REG_KIND, {31'b0, kind});
        reg_write(`FEEDER_REG_SRAM_IDX, sram);
        reg_write(`FEEDER_REG_MODE, {31'b0, probe});
        reg_write(`FEEDER_REG_START, 32'd1);
    endtask

    task automatic finish_job();
        logic [31:0] rd;
        rd = 32'd1;
        while (rd[0]) bus_access(`FEEDER_REG_BUSY, 32'd0, rd);
        while (credit_owed > 0) @(negedge clk_i);
        if (req_log.size() != exp_req.size())
            note_error($sformatf("saw %0d requests, wanted %0d", req_log.size(), exp_req.size()));
        if (cmd_log.size() != exp_cmd.size())
            note_error($sformatf("saw %0d commands, wanted %0d", cmd_log.size(), exp_cmd.size()));
        foreach (exp_req[i]) if (i < req_log.size()) check_req(exp_req[i], req_log[i]);
        foreach (exp_cmd[i]) if (i < cmd_log.size()) check_cmd(exp_cmd[i], cmd_log[i]);
        if (req_q.size() != 0 || line_present) note_error("DRAM model still holds unread lines");
    endtask

    // ############################################################
    // directed tests
    // ############################################################
    task automatic test_reset_access();
        logic [31:0] rd;
        begin_test("reset_access");
        if (req_valid_o || fifo_rd_en_o || cmd_valid_o || ready_o)
            note_error("a handshake output is active after reset");
        reg_write(`FEEDER_REG_DRAM_ADDR, 32'h0);
        reg_write(`FEEDER_REG_LENGTH, 32'h0);
        reg_write(`FEEDER_REG_SRAM_IDX, 32'h0);
        reg_write(`FEEDER_REG_RD_ROUNDS, 32'h1);
        bus_access(`FEEDER_REG_PROBE, 32'h0, rd);
        bus_access(`FEEDER_REG_BUSY, 32'h0, rd);
        check_rdata(32'h0, rd);
        end_test();
    endtask

    task automatic test_aligned();
        begin_test("aligned_job");
        start_job(32'h1000, 32, 0, 1, CMD_LOAD_INPUT, 'h100, 1'b0);
        finish_job();
        end_test();
    endtask

    task automatic test_unaligned();
        begin_test("unaligned_job");
        start_job(32'h1010, 40, 0, 1, CMD_LOAD_WEIGHT, 'h20, 1'b0);
        finish_job();
        end_test();
    endtask

    task automatic test_two_rounds();
        begin_test("two_rounds");
        start_job(32'h2000, 48, 'h200, 2, CMD_LOAD_INPUT, 'h300, 1'b0);
        finish_job();
        end_test();
    endtask

    task automatic test_credit_hold();
        begin_test("credit_hold");
        hold_credits = 1'b1;
        start_job(32'h4000, 16, 0, 1, CMD_LOAD_INPUT, 'h40, 1'b0);
        repeat (40) @(negedge clk_i);
        if (cmd_log.size() != `FEEDER_CMD_CREDITS)
            note_error($sformatf("saw %0d commands with credits withheld", cmd_log.size()));
        hold_credits = 1'b0;
        finish_job();
        end_test();
    endtask

    task automatic test_probe();
        logic [31:0] rd;
        begin_test("probe_mode");
        start_job(32'h3008, 8, 0, 1, CMD_LOAD_INPUT, 0, 1'b1);
        finish_job();
        bus_access(`FEEDER_REG_PROBE, 32'h0, rd);
        check_rdata({16'h0, word_val(32'h3000, 5'd4)}, rd);
        reg_write(`FEEDER_REG_MODE, 32'h0);
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_i        = 1'b1;
        mmio_i       = '0;
        addr_full_i  = 1'b0;
        rw_full_i    = 1'b0;
        data_empty_i = 1'b1;
        data_h_i     = '0;
        data_l_i     = '0;
        credit_i     = 1'b0;
        gap          = 0;
        credit_owed  = 0;
        credit_wait  = 0;
        line_present = 1'b0;
        pop_pending  = 1'b0;
        hold_credits = 1'b0;
        cur_test     = "reset";
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        test_reset_access();
        test_aligned();
        test_unaligned();
        test_two_rounds();
        test_credit_hold();
        test_probe();
        errors += data_feeder_inst.data_feeder_chk_inst.assert_fails;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
